//--- logic/ctr_pkg.sv
`default_nettype none

package ctr_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int LANES       = 8;               // Counter updates per beat.
  localparam int ENTRIES     = 256;
  localparam int INDEX_W     = 8;
  localparam int COUNT_W     = 32;
  localparam int INCR_W      = 16;
  localparam int FIFO_DEPTH  = 4;               // Also the sender's starting credit.
  localparam int CLEAR_STEPS = ENTRIES / LANES; // One row of LANES entries per step.

  //////////////////////////////
  // Types
  //////////////////////////////
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [INCR_W-1:0]  incr_t;
  typedef logic [LANES-1:0]   lane_mask_t;
  typedef logic [1:0]         op_t;

  localparam op_t OP_UPDATE    = 2'd0;
  localparam op_t OP_READ      = 2'd1;
  localparam op_t OP_CLEAR_ALL = 2'd2;

  typedef enum logic {ST_RUN, ST_CLEAR} ctl_state_t;

endpackage

`default_nettype wire

//--- logic/beat_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module beat_fifo (
  input  wire                                     clock,
  input  wire                                     reset_n,
  input  wire                                     in_valid,
  input  wire ctr_pkg::op_t                       in_op,
  input  wire ctr_pkg::lane_mask_t                in_mask,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] in_index,
  input  wire ctr_pkg::incr_t  [ctr_pkg::LANES-1:0] in_incr,
  input  wire                                     pop,
  output logic                                    head_valid,
  output ctr_pkg::op_t                            head_op,
  output ctr_pkg::lane_mask_t                     head_mask,
  output ctr_pkg::index_t [ctr_pkg::LANES-1:0]    head_index,
  output ctr_pkg::incr_t  [ctr_pkg::LANES-1:0]    head_incr,
  output logic                                    credit_return
);

  ctr_pkg::op_t                         op_mem    [ctr_pkg::FIFO_DEPTH];
  ctr_pkg::lane_mask_t                  mask_mem  [ctr_pkg::FIFO_DEPTH];
  ctr_pkg::index_t [ctr_pkg::LANES-1:0] index_mem [ctr_pkg::FIFO_DEPTH];
  ctr_pkg::incr_t  [ctr_pkg::LANES-1:0] incr_mem  [ctr_pkg::FIFO_DEPTH];

  logic [$clog2(ctr_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(ctr_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(ctr_pkg::FIFO_DEPTH+1)-1:0] fill_count;

  always_ff @(posedge clock)
  begin
    if (in_valid)
    begin
      op_mem[wr_ptr]    <= in_op;
      mask_mem[wr_ptr]  <= in_mask;
      index_mem[wr_ptr] <= in_index;
      incr_mem[wr_ptr]  <= in_incr;
    end
  end

  always_ff @(posedge clock)
  begin
    if (!reset_n)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill_count    <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= wr_ptr + 1'b1; // Pointers wrap with the depth.
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({in_valid, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
      credit_return <= pop; // One credit back per retired beat.
    end
  end

  assign head_valid = (fill_count != '0);
  assign head_op    = op_mem[rd_ptr];
  assign head_mask  = mask_mem[rd_ptr];
  assign head_index = index_mem[rd_ptr];
  assign head_incr  = incr_mem[rd_ptr];

endmodule

`default_nettype wire

//--- logic/lane_merge.sv
`timescale 1ns/10ps
`default_nettype none

module lane_merge (
  input  wire ctr_pkg::lane_mask_t                head_mask,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] head_index,
  input  wire ctr_pkg::incr_t  [ctr_pkg::LANES-1:0] head_incr,
  output ctr_pkg::lane_mask_t                     merged_mask,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    merged_incr
);

  //////////////////////////////
  // Same-index folding
  //////////////////////////////
  // Every lane sums the increments of all active lanes sharing its index.
  // Only the lowest of those lanes keeps its enable, so each counter sees
  // exactly one read-modify-write per beat.
  always_comb
  begin : fold
    ctr_pkg::count_t sum;
    logic            lowest;
    for (int i = 0; i < ctr_pkg::LANES; i++)
    begin
      sum    = '0;
      lowest = head_mask[i];
      for (int j = 0; j < ctr_pkg::LANES; j++)
      begin
        if (head_mask[j] && (head_index[j] == head_index[i]))
        begin
          sum = sum + ctr_pkg::count_t'(head_incr[j]); // Eight 16-bit terms fit easily.
          if (j < i)
            lowest = 1'b0;                             // A lower lane owns this index.
        end
      end
      merged_mask[i] = lowest;
      merged_incr[i] = lowest ? sum : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/ram_8p.sv
`timescale 1ns/10ps
`default_nettype none

module ram_8p (
  input  wire                                     clock,
  input  wire                                     reset_n,
  input  wire ctr_pkg::lane_mask_t                we,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] windex,
  input  wire ctr_pkg::count_t [ctr_pkg::LANES-1:0] wdata,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] rindex,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    rdata
);

  ctr_pkg::count_t ram_f [ctr_pkg::ENTRIES];

  //////////////////////////////
  // Write ports
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (!reset_n)
    begin
      for (int e = 0; e < ctr_pkg::ENTRIES; e++)
        ram_f[e] <= '0;
    end
    else
    begin
      // Later ports override earlier ones on equal indexes.
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        if (we[n])
          ram_f[windex[n]] <= wdata[n];
      end
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////
  always_comb
  begin
    for (int n = 0; n < ctr_pkg::LANES; n++)
      rdata[n] = ram_f[rindex[n]]; // Combinational read.
  end

endmodule

`default_nettype wire

//--- logic/count_update.sv
`timescale 1ns/10ps
`default_nettype none

module count_update (
  input  wire                                     clock,
  input  wire                                     reset_n,
  input  wire ctr_pkg::count_t [ctr_pkg::LANES-1:0] rdata,
  input  wire ctr_pkg::count_t [ctr_pkg::LANES-1:0] merged_incr,
  input  wire                                     capture,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    next_count,
  output logic                                    rd_valid,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    rd_data
);

  always_comb
  begin : add
    logic [ctr_pkg::COUNT_W:0] wide;
    for (int n = 0; n < ctr_pkg::LANES; n++)
    begin
      wide = {1'b0, rdata[n]} + {1'b0, merged_incr[n]};
      if (wide[ctr_pkg::COUNT_W])
        next_count[n] = '1;                              // Clamp at maximum.
      else
        next_count[n] = wide[ctr_pkg::COUNT_W-1:0];
    end
  end

  //////////////////////////////
  // Read result stage
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (!reset_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= capture; // Single-cycle strobe.
  end

  always_ff @(posedge clock)
  begin
    if (capture)
      rd_data <= rdata;
  end

endmodule

`default_nettype wire

//--- logic/ctr_control.sv
`timescale 1ns/10ps
`default_nettype none

module ctr_control (
  input  wire                                     clock,
  input  wire                                     reset_n,
  input  wire                                     head_valid,
  input  wire ctr_pkg::op_t                       head_op,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] head_index,
  input  wire ctr_pkg::lane_mask_t                merged_mask,
  input  wire ctr_pkg::count_t [ctr_pkg::LANES-1:0] next_count,
  output logic                                    pop,
  output ctr_pkg::lane_mask_t                     we,
  output ctr_pkg::index_t [ctr_pkg::LANES-1:0]    windex,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    wdata,
  output ctr_pkg::index_t [ctr_pkg::LANES-1:0]    rindex,
  output logic                                    capture
);

  ctr_pkg::ctl_state_t                      state;
  logic [$clog2(ctr_pkg::CLEAR_STEPS)-1:0]  sweep_step;

  assign pop     = (state == ctr_pkg::ST_RUN) && head_valid;
  assign capture = pop && (head_op == ctr_pkg::OP_READ);
  assign rindex  = head_index; // Lanes always read the head beat's indexes.

  //////////////////////////////
  // Write port steering
  //////////////////////////////
  always_comb
  begin
    if (state == ctr_pkg::ST_CLEAR)
    begin
      we = '1;
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        windex[n] = ctr_pkg::index_t'(int'(sweep_step) * ctr_pkg::LANES + n);
        wdata[n]  = '0;
      end
    end
    else
    begin
      we     = (pop && (head_op == ctr_pkg::OP_UPDATE)) ? merged_mask : '0;
      windex = head_index;
      wdata  = next_count;
    end
  end

  //////////////////////////////
  // State and sweep
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (!reset_n)
    begin
      state      <= ctr_pkg::ST_RUN;
      sweep_step <= '0;
    end
    else
    begin
      case (state)
        ctr_pkg::ST_RUN:
        begin
          sweep_step <= '0;
          if (pop && (head_op == ctr_pkg::OP_CLEAR_ALL))
            state <= ctr_pkg::ST_CLEAR;
        end
        default:
        begin
          if (int'(sweep_step) == ctr_pkg::CLEAR_STEPS - 1)
          begin
            state      <= ctr_pkg::ST_RUN; // Last row written this cycle.
            sweep_step <= '0;
          end
          else
            sweep_step <= sweep_step + 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/counter_table.sv
`timescale 1ns/10ps
`default_nettype none

module counter_table (
  input  wire                                     clock,
  input  wire                                     reset_n,
  input  wire                                     in_valid,
  input  wire ctr_pkg::op_t                       in_op,
  input  wire ctr_pkg::lane_mask_t                in_mask,
  input  wire ctr_pkg::index_t [ctr_pkg::LANES-1:0] in_index,
  input  wire ctr_pkg::incr_t  [ctr_pkg::LANES-1:0] in_incr,
  output logic                                    credit_return,
  output logic                                    rd_valid,
  output ctr_pkg::count_t [ctr_pkg::LANES-1:0]    rd_data
);

  logic                                  head_valid;
  ctr_pkg::op_t                          head_op;
  ctr_pkg::lane_mask_t                   head_mask;
  ctr_pkg::index_t [ctr_pkg::LANES-1:0]  head_index;
  ctr_pkg::incr_t  [ctr_pkg::LANES-1:0]  head_incr;
  logic                                  pop;
  ctr_pkg::lane_mask_t                   merged_mask;
  ctr_pkg::count_t [ctr_pkg::LANES-1:0]  merged_incr;
  ctr_pkg::lane_mask_t                   we;
  ctr_pkg::index_t [ctr_pkg::LANES-1:0]  windex;
  ctr_pkg::count_t [ctr_pkg::LANES-1:0]  wdata;
  ctr_pkg::index_t [ctr_pkg::LANES-1:0]  rindex;
  ctr_pkg::count_t [ctr_pkg::LANES-1:0]  rdata;
  ctr_pkg::count_t [ctr_pkg::LANES-1:0]  next_count;
  logic                                  capture;

  beat_fifo i_beat_fifo (
    .clock, .reset_n,
    .in_valid, .in_op, .in_mask, .in_index, .in_incr,
    .pop,
    .head_valid, .head_op, .head_mask, .head_index, .head_incr,
    .credit_return
  );

  lane_merge i_lane_merge (
    .head_mask, .head_index, .head_incr,
    .merged_mask, .merged_incr
  );

  ctr_control i_ctr_control (
    .clock, .reset_n,
    .head_valid, .head_op, .head_index,
    .merged_mask, .next_count,
    .pop, .we, .windex, .wdata, .rindex, .capture
  );

  ram_8p i_ram_8p (
    .clock, .reset_n,
    .we, .windex, .wdata,
    .rindex, .rdata
  );

  count_update i_count_update (
    .clock, .reset_n,
    .rdata, .merged_incr, .capture,
    .next_count, .rd_valid, .rd_data
  );

endmodule

`default_nettype wire

//--- bench/counter_table_chk.sv
`timescale 1ns/10ps
`default_nettype none

module counter_table_chk (
  input wire               clock,
  input wire               reset_n,
  input wire               in_valid,
  input wire               pop,
  input wire ctr_pkg::op_t head_op,
  input wire               credit_return,
  input wire               rd_valid
);

  logic [3:0] fill_track; // Beats held in the ingress buffer.

  always_ff @(posedge clock)
  begin
    if (!reset_n)
      fill_track <= '0;
    else
      fill_track <= fill_track + {3'b000, in_valid} - {3'b000, pop};
  end

  //////////////////////////////
  // Credit and result rules
  //////////////////////////////
  fill_in_range: assert property (@(posedge clock) disable iff (!reset_n)
    fill_track <= 4'(ctr_pkg::FIFO_DEPTH))
    else $error("ingress buffer holds more beats than its depth");

  credit_after_pop: assert property (@(posedge clock) disable iff (!reset_n)
    credit_return |-> $past(pop))
    else $error("credit returned without a pop in the cycle before");

  no_read_on_clear: assert property (@(posedge clock) disable iff (!reset_n)
    rd_valid |-> !$past(pop && (head_op == ctr_pkg::OP_CLEAR_ALL)))
    else $error("read result strobed for a clear-all beat");

endmodule

`default_nettype wire

//--- bench/counter_table_tb.sv
`timescale 1ns/10ps
`default_nettype none

module counter_table_tb;

  typedef ctr_pkg::index_t [ctr_pkg::LANES-1:0] index_vec_t;
  typedef ctr_pkg::incr_t  [ctr_pkg::LANES-1:0] incr_vec_t;
  typedef ctr_pkg::count_t [ctr_pkg::LANES-1:0] count_vec_t;

  localparam int SAT_BEATS   = 8200; // 8192 all-lane beats of 16'hffff stay just below 2**32.
  localparam int N_RANDOM    = 600;
  localparam int BEATS       = 32 + 68 + 9 + (SAT_BEATS + 7) + 35 + (N_RANDOM + 32);
  localparam int TIMEOUT     = 4 * (BEATS + ctr_pkg::CLEAR_STEPS + 256);
  localparam int DRAIN_LIMIT = 2 * ctr_pkg::CLEAR_STEPS + 16 * ctr_pkg::FIFO_DEPTH;

  logic                clock;
  logic                reset_n;
  logic                in_valid;
  ctr_pkg::op_t        in_op;
  ctr_pkg::lane_mask_t in_mask;
  index_vec_t          in_index;
  incr_vec_t           in_incr;
  logic                credit_return;
  logic                rd_valid;
  count_vec_t          rd_data;

  ctr_pkg::count_t shadow [ctr_pkg::ENTRIES]; // Reference copy of the table.
  count_vec_t      exp_q [$];
  int              seed = 32'hf2ef_706d;
  int              sent_cnt = 0;
  int              back_cnt = 0;
  int              err_cnt = 0;
  int              read_cnt = 0;
  int              test_cnt = 0;
  int              err_mark = 0;

  counter_table i_counter_table (
    .clock, .reset_n, .in_valid, .in_op, .in_mask, .in_index, .in_incr,
    .credit_return, .rd_valid, .rd_data
  );

  bind counter_table counter_table_chk i_counter_table_chk (
    .clock, .reset_n, .in_valid, .pop, .head_op, .credit_return, .rd_valid
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Lanes are applied one after another; clamping at each step gives the
  // same result as summing shared lanes first and clamping once.
  function automatic count_vec_t model_beat(input ctr_pkg::op_t op,
                                            input ctr_pkg::lane_mask_t mask,
                                            input index_vec_t idx, input incr_vec_t inc);
    count_vec_t result;
    longint     sum;
    result = '0;
    if (op == ctr_pkg::OP_UPDATE)
    begin
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        if (mask[n])
        begin
          sum = longint'(shadow[idx[n]]) + longint'(inc[n]);
          if (sum > 64'hffff_ffff)
            sum = 64'hffff_ffff; // Counter maximum.
          shadow[idx[n]] = ctr_pkg::count_t'(sum);
        end
      end
    end
    else if (op == ctr_pkg::OP_READ)
    begin
      for (int n = 0; n < ctr_pkg::LANES; n++)
        result[n] = shadow[idx[n]];
    end
    else if (op == ctr_pkg::OP_CLEAR_ALL)
    begin
      for (int e = 0; e < ctr_pkg::ENTRIES; e++)
        shadow[e] = '0;
    end
    return result;
  endfunction

  always @(posedge clock)
  begin
    if (reset_n && credit_return)
      back_cnt++;
  end

  always @(negedge clock)
  begin : compare
    count_vec_t expected;
    if (reset_n && rd_valid)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        $display("Read result at %0t arrived with no read outstanding", $time);
        err_cnt++;
      end
      if (exp_q.size() != 0)
      begin
        expected = exp_q.pop_front();
        read_cnt++;
        assert (rd_data == expected)
        else
        begin
          $display("MISMATCH at %0t: read %0d expected %h got %h",
                   $time, read_cnt, expected, rd_data);
          err_cnt++;
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic send_beat(input ctr_pkg::op_t op, input ctr_pkg::lane_mask_t mask,
                           input index_vec_t idx, input incr_vec_t inc);
    count_vec_t expected;
    @(negedge clock);
    while (ctr_pkg::FIFO_DEPTH - sent_cnt + back_cnt <= 0)
    begin
      in_valid = 1'b0; // Out of credits.
      @(negedge clock);
    end
    in_valid = 1'b1;
    in_op    = op;
    in_mask  = mask;
    in_index = idx;
    in_incr  = inc;
    sent_cnt++;
    expected = model_beat(op, mask, idx, inc);
    if (op == ctr_pkg::OP_READ)
      exp_q.push_back(expected);
  endtask

  task automatic read_rows(input int first, input int rows);
    index_vec_t idx;
    for (int r = first; r < first + rows; r++)
    begin
      for (int n = 0; n < ctr_pkg::LANES; n++)
        idx[n] = ctr_pkg::index_t'(r * ctr_pkg::LANES + n);
      send_beat(ctr_pkg::OP_READ, '0, idx, '0);
    end
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    @(negedge clock);
    in_valid = 1'b0;
    while ((exp_q.size() != 0 || back_cnt != sent_cnt) && waited < DRAIN_LIMIT)
    begin
      @(negedge clock);
      waited++;
    end
    assert (back_cnt == sent_cnt)
    else
    begin
      $display("Credits missing after %s: %0d sent, %0d returned", name, sent_cnt, back_cnt);
      err_cnt++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      $display("%0d read results never arrived in %s", exp_q.size(), name);
      err_cnt++;
    end
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial
  begin : main
    index_vec_t  idx;
    incr_vec_t   inc;
    logic [31:0] r;
    in_valid = 1'b0;
    in_op    = ctr_pkg::OP_UPDATE;
    in_mask  = '0;
    in_index = '0;
    in_incr  = '0;
    reset_n  = 1'b0;
    for (int e = 0; e < ctr_pkg::ENTRIES; e++)
      shadow[e] = '0;
    repeat (16) @(negedge clock);
    reset_n = 1'b1;

    read_rows(0, ctr_pkg::CLEAR_STEPS);
    finish_test("reads after reset");

    // One active lane per beat; indexes repeat after 32 beats.
    for (int k = 0; k < 64; k++)
    begin
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        idx[n] = ctr_pkg::index_t'(k % 32);
        inc[n] = '0;
      end
      inc[k % 8] = ctr_pkg::incr_t'($random(seed));
      send_beat(ctr_pkg::OP_UPDATE, ctr_pkg::lane_mask_t'(1 << (k % 8)), idx, inc);
    end
    read_rows(0, 4);
    finish_test("single lane sums");

    for (int t = 0; t < 8; t++)
    begin
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        idx[n] = ctr_pkg::index_t'(64 + (t + n) % 3); // Three indexes shared by eight lanes.
        inc[n] = ctr_pkg::incr_t'($random(seed));
      end
      send_beat(ctr_pkg::OP_UPDATE, 8'hff, idx, inc);
    end
    read_rows(8, 1);
    finish_test("shared index merge");

    for (int n = 0; n < ctr_pkg::LANES; n++)
    begin
      idx[n] = 8'd200;
      inc[n] = 16'hffff;
    end
    for (int b = 0; b < SAT_BEATS + 4; b++)
    begin
      send_beat(ctr_pkg::OP_UPDATE, 8'hff, idx, inc);
      if (b == 8191 || b == SAT_BEATS - 1 || b == SAT_BEATS + 3)
        send_beat(ctr_pkg::OP_READ, '0, idx, inc);
    end
    finish_test("saturation");

    // These beats queue behind the sweep.
    send_beat(ctr_pkg::OP_CLEAR_ALL, '0, idx, inc);
    read_rows(0, 1);
    for (int n = 0; n < ctr_pkg::LANES; n++)
    begin
      idx[n] = ctr_pkg::index_t'(n);
      inc[n] = 16'd7;
    end
    send_beat(ctr_pkg::OP_UPDATE, 8'h08, idx, inc);
    read_rows(0, ctr_pkg::CLEAR_STEPS);
    finish_test("clear-all");

    for (int b = 0; b < N_RANDOM; b++)
    begin
      r = $random(seed);
      for (int n = 0; n < ctr_pkg::LANES; n++)
      begin
        idx[n] = ctr_pkg::index_t'($random(seed) & 31);
        inc[n] = ctr_pkg::incr_t'($random(seed));
      end
      send_beat((r[1:0] == 2'd0) ? ctr_pkg::OP_READ : ctr_pkg::OP_UPDATE,
                ctr_pkg::lane_mask_t'(r[15:8]), idx, inc);
    end
    read_rows(0, ctr_pkg::CLEAR_STEPS);
    finish_test("random mix");

    $display("%0d tests, %0d reads compared, %0d errors", test_cnt, read_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT)
    begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/ctr_pkg.sv
logic/beat_fifo.sv
logic/lane_merge.sv
logic/ram_8p.sv
logic/count_update.sv
logic/ctr_control.sv
logic/counter_table.sv
bench/counter_table_chk.sv
bench/counter_table_tb.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      := counter_table_tb
FLIST    := flist.f
OBJDIR   := obj_dir
SIM_BIN  := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED
SOURCES  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
